//--- hw/conv_pkg.sv
package conv_pkg;

	// fixed-point format of the coefficients
	localparam int FRAC_BITS = 8;
	localparam int NUM_TAPS = 9;

	typedef logic signed [15:0] pixel_t;
	typedef logic signed [15:0] coef_t;
	// nine 32-bit products plus the shifted bias
	typedef logic signed [39:0] acc_t;
	typedef logic [7:0] coord_t;
	typedef logic [15:0] addr_t;

	typedef struct packed {
		logic en;
		addr_t addr;
	} coef_rd_t;

	typedef struct packed {
		logic en;
		coord_t row;
		coord_t col;
	} pix_rd_t;

	typedef struct packed {
		coord_t row;
		coord_t col;
	} out_coord_t;

endpackage

//--- hw/coef_loader.sv
module coef_loader #(
	parameter int NUM_COEF = 9
) (
	input logic clk,
	input logic rst,
	input logic store_done,
	input conv_pkg::coef_t rd_data,
	output conv_pkg::coef_rd_t rd,
	output conv_pkg::coef_t coefs [NUM_COEF],
	output logic ready
);

	typedef enum logic {
		idle,
		load
	} load_state_t;

	localparam conv_pkg::addr_t last_addr = conv_pkg::addr_t'(NUM_COEF - 1);

	load_state_t state;
	logic req_en;
	conv_pkg::addr_t req_cnt;
	logic cap_en;
	conv_pkg::addr_t cap_cnt;

	assign rd = '{en: req_en, addr: req_cnt};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= idle;
			req_en <= 1'b0;
			req_cnt <= '0;
			cap_en <= 1'b0;
			cap_cnt <= '0;
			ready <= 1'b0;
		end
		else
		begin
			// memory answers one cycle after the request
			cap_en <= req_en;
			case (state)
			idle:
			begin
				if (store_done)
				begin
					state <= load;
					req_en <= 1'b1;
					req_cnt <= '0;
					cap_cnt <= '0;
					ready <= 1'b0;
				end
			end
			load:
			begin
				if (req_en)
				begin
					if (req_cnt == last_addr)
						req_en <= 1'b0;
					else
						req_cnt <= req_cnt + 1'b1;
				end
				if (cap_en)
				begin
					cap_cnt <= cap_cnt + 1'b1;
					if (cap_cnt == last_addr)
					begin
						state <= idle;
						ready <= 1'b1;
					end
				end
			end
			default:
				state <= idle;
			endcase
		end
	end

	// new words enter at the top, so entry k ends up with address k
	always_ff @(posedge clk)
	begin
		if (cap_en)
		begin
			coefs[NUM_COEF-1] <= rd_data;
			for (int k = 0; k < NUM_COEF - 1; k++)
				coefs[k] <= coefs[k+1];
		end
	end

endmodule

//--- hw/line_window.sv
module line_window #(
	parameter int IMG_WIDTH = 8
) (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input conv_pkg::pixel_t pix_in,
	output conv_pkg::pixel_t window [conv_pkg::NUM_TAPS]
);

	// three window stages plus the delay line make one image row
	localparam int DELAY = IMG_WIDTH - 3;

	// line_buf[0] feeds the top row, line_buf[1] the middle row
	conv_pkg::pixel_t line_buf [2][DELAY];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int t = 0; t < conv_pkg::NUM_TAPS; t++)
				window[t] <= '0;
			for (int r = 0; r < 2; r++)
			begin
				for (int s = 0; s < DELAY; s++)
					line_buf[r][s] <= '0;
			end
		end
		else if (pix_valid)
		begin
			// shift each window row towards its left tap
			for (int r = 0; r < 3; r++)
			begin
				window[3*r+1] <= window[3*r+2];
				window[3*r] <= window[3*r+1];
			end
			// newest pixel is the bottom-right tap
			window[8] <= pix_in;
			for (int r = 0; r < 2; r++)
			begin
				window[3*r+2] <= line_buf[r][DELAY-1];
				line_buf[r][0] <= window[3*r+3];
				for (int s = 1; s < DELAY; s++)
					line_buf[r][s] <= line_buf[r][s-1];
			end
		end
	end

endmodule

//--- hw/conv_mac.sv
module conv_mac (
	input logic clk,
	input logic rst,
	input logic en,
	input conv_pkg::pixel_t window [conv_pkg::NUM_TAPS],
	input conv_pkg::coef_t weights [conv_pkg::NUM_TAPS],
	input conv_pkg::coef_t bias,
	output conv_pkg::pixel_t result
);

	conv_pkg::acc_t sum;
	conv_pkg::acc_t scaled;

	// bias is aligned to the product scale before the sum
	always_comb
	begin
		sum = conv_pkg::acc_t'(bias) <<< conv_pkg::FRAC_BITS;
		for (int t = 0; t < conv_pkg::NUM_TAPS; t++)
			sum = sum + conv_pkg::acc_t'(window[t]) * conv_pkg::acc_t'(weights[t]);
	end

	assign scaled = sum >>> conv_pkg::FRAC_BITS;

	// low 16 bits only, wraps on overflow
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			result <= '0;
		else if (en)
			result <= scaled[15:0];
	end

endmodule

//--- hw/scan_ctrl.sv
module scan_ctrl #(
	parameter int IMG_WIDTH = 8
) (
	input logic clk,
	input logic rst,
	input logic pixel_store_done,
	input logic weights_ready,
	input logic bias_ready,
	output conv_pkg::pix_rd_t pix_rd,
	output logic pix_valid,
	output logic mac_en,
	output logic out_valid,
	output conv_pkg::out_coord_t out_coord,
	output logic conv_done
);

	typedef enum logic {
		idle,
		run
	} scan_state_t;

	localparam conv_pkg::coord_t last_idx = conv_pkg::coord_t'(IMG_WIDTH - 1);

	scan_state_t state;
	conv_pkg::coord_t rd_row;
	conv_pkg::coord_t rd_col;
	conv_pkg::coord_t arr_row;
	conv_pkg::coord_t arr_col;
	conv_pkg::out_coord_t mac_coord;
	logic mac_last;

	assign pix_rd = '{en: (state == run), row: rd_row, col: rd_col};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= idle;
			rd_row <= '0;
			rd_col <= '0;
		end
		else
		begin
			case (state)
			idle:
			begin
				// frame only starts with all coefficients in place
				if (pixel_store_done && weights_ready && bias_ready)
				begin
					state <= run;
					rd_row <= '0;
					rd_col <= '0;
				end
			end
			run:
			begin
				if (rd_col == last_idx)
				begin
					rd_col <= '0;
					if (rd_row == last_idx)
						state <= idle;
					else
						rd_row <= rd_row + 1'b1;
				end
				else
				begin
					rd_col <= rd_col + 1'b1;
				end
			end
			default:
				state <= idle;
			endcase
		end
	end

	// arr_* follow the pixel now on the data bus
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pix_valid <= 1'b0;
			arr_row <= '0;
			arr_col <= '0;
			mac_en <= 1'b0;
			mac_last <= 1'b0;
			out_valid <= 1'b0;
			conv_done <= 1'b0;
		end
		else
		begin
			pix_valid <= pix_rd.en;
			arr_row <= rd_row;
			arr_col <= rd_col;
			// window is full once two rows and two columns are in
			mac_en <= pix_valid && (arr_row >= 2) && (arr_col >= 2);
			mac_last <= pix_valid && (arr_row == last_idx) && (arr_col == last_idx);
			out_valid <= mac_en;
			conv_done <= mac_last;
		end
	end

	always_ff @(posedge clk)
	begin
		mac_coord.row <= arr_row - conv_pkg::coord_t'(2);
		mac_coord.col <= arr_col - conv_pkg::coord_t'(2);
		out_coord <= mac_coord;
	end

endmodule

//--- hw/layer1_conv.sv
module layer1_conv #(
	parameter int OUT_CH = 4,
	parameter int IMG_WIDTH = 8
) (
	input logic clk,
	input logic rst,
	input logic weight_store_done,
	input logic bias_store_done,
	input logic pixel_store_done,
	input conv_pkg::coef_t weight_data,
	input conv_pkg::coef_t bias_data,
	input conv_pkg::pixel_t pixel_data,
	output conv_pkg::coef_rd_t weight_rd,
	output conv_pkg::coef_rd_t bias_rd,
	output conv_pkg::pix_rd_t pix_rd,
	output logic out_valid,
	output conv_pkg::out_coord_t out_coord,
	output conv_pkg::pixel_t out_data [OUT_CH],
	output logic conv_done
);

	localparam int NUM_WEIGHTS = conv_pkg::NUM_TAPS * OUT_CH;

	conv_pkg::coef_t weight_coefs [NUM_WEIGHTS];
	conv_pkg::coef_t bias_coefs [OUT_CH];
	conv_pkg::pixel_t window [conv_pkg::NUM_TAPS];
	logic weights_ready;
	logic bias_ready;
	logic pix_valid;
	logic mac_en;

	coef_loader #(
		.NUM_COEF(NUM_WEIGHTS)
	) weight_loader_i (
		.clk(clk),
		.rst(rst),
		.store_done(weight_store_done),
		.rd_data(weight_data),
		.rd(weight_rd),
		.coefs(weight_coefs),
		.ready(weights_ready)
	);

	coef_loader #(
		.NUM_COEF(OUT_CH)
	) bias_loader_i (
		.clk(clk),
		.rst(rst),
		.store_done(bias_store_done),
		.rd_data(bias_data),
		.rd(bias_rd),
		.coefs(bias_coefs),
		.ready(bias_ready)
	);

	line_window #(
		.IMG_WIDTH(IMG_WIDTH)
	) line_window_i (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.pix_in(pixel_data),
		.window(window)
	);

	scan_ctrl #(
		.IMG_WIDTH(IMG_WIDTH)
	) scan_ctrl_i (
		.clk(clk),
		.rst(rst),
		.pixel_store_done(pixel_store_done),
		.weights_ready(weights_ready),
		.bias_ready(bias_ready),
		.pix_rd(pix_rd),
		.pix_valid(pix_valid),
		.mac_en(mac_en),
		.out_valid(out_valid),
		.out_coord(out_coord),
		.conv_done(conv_done)
	);

	for (genvar ch = 0; ch < OUT_CH; ch++)
	begin : g_ch
		conv_pkg::coef_t ch_weights [conv_pkg::NUM_TAPS];

		// weight memory is tap-major, channel-minor
		for (genvar t = 0; t < conv_pkg::NUM_TAPS; t++)
		begin : g_tap
			assign ch_weights[t] = weight_coefs[t*OUT_CH+ch];
		end

		conv_mac conv_mac_i (
			.clk(clk),
			.rst(rst),
			.en(mac_en),
			.window(window),
			.weights(ch_weights),
			.bias(bias_coefs[ch]),
			.result(out_data[ch])
		);
	end

endmodule

//--- dv/layer1_conv_tb.sv
module layer1_conv_tb;

	localparam int OUT_CH = 4;
	localparam int IMG_WIDTH = 8;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_WEIGHTS = conv_pkg::NUM_TAPS * OUT_CH;
	localparam int OUT_W = IMG_WIDTH - 2;
	localparam int OUT_PER_FRAME = OUT_W * OUT_W;
	localparam int ONE = 1 << conv_pkg::FRAC_BITS;
	// cycle budgets for one load, one frame and the reset test
	localparam int LOAD_CYCLES = NUM_WEIGHTS + 10;
	localparam int FRAME_CYCLES = IMG_WIDTH * IMG_WIDTH + 10;
	localparam int RESET_CYCLES = 4 * IMG_WIDTH;
	localparam int NUM_LOADS = 4;
	localparam int NUM_FRAMES = 4;
	localparam int WATCHDOG_CYCLES =
		2 * (RESET_CYCLES + NUM_LOADS * LOAD_CYCLES + NUM_FRAMES * FRAME_CYCLES);

	logic clk;
	logic rst;
	logic weight_store_done;
	logic bias_store_done;
	logic pixel_store_done;
	conv_pkg::coef_t weight_data;
	conv_pkg::coef_t bias_data;
	conv_pkg::pixel_t pixel_data;
	conv_pkg::coef_rd_t weight_rd;
	conv_pkg::coef_rd_t bias_rd;
	conv_pkg::pix_rd_t pix_rd;
	logic out_valid;
	conv_pkg::out_coord_t out_coord;
	conv_pkg::pixel_t out_data [OUT_CH];
	logic conv_done;

	conv_pkg::coef_t weight_mem [NUM_WEIGHTS];
	conv_pkg::coef_t bias_mem [OUT_CH];
	conv_pkg::pixel_t pix_mem [IMG_WIDTH*IMG_WIDTH];
	conv_pkg::pixel_t exp_out [OUT_PER_FRAME][OUT_CH];
	conv_pkg::out_coord_t exp_coord;
	int out_cnt;
	int seed;

	layer1_conv #(
		.OUT_CH(OUT_CH),
		.IMG_WIDTH(IMG_WIDTH)
	) layer1_conv_i (
		.clk(clk),
		.rst(rst),
		.weight_store_done(weight_store_done),
		.bias_store_done(bias_store_done),
		.pixel_store_done(pixel_store_done),
		.weight_data(weight_data),
		.bias_data(bias_data),
		.pixel_data(pixel_data),
		.weight_rd(weight_rd),
		.bias_rd(bias_rd),
		.pix_rd(pix_rd),
		.out_valid(out_valid),
		.out_coord(out_coord),
		.out_data(out_data),
		.conv_done(conv_done)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// memories answer one cycle after the request
	always @(posedge clk)
	begin
		if (weight_rd.en)
			weight_data <= weight_mem[weight_rd.addr];
		if (bias_rd.en)
			bias_data <= bias_mem[bias_rd.addr];
		if (pix_rd.en)
			pixel_data <= pix_mem[pix_rd.row*IMG_WIDTH+pix_rd.col];
	end

	task automatic stop_run(string line);
		$display("%s", line);
		$display("TB FAILED");
		$fatal(1);
	endtask

	function automatic string error_text(string msg);
		return $sformatf("ERROR at time %0t: %s", $time, msg);
	endfunction

	task automatic check_coord(conv_pkg::out_coord_t got, conv_pkg::out_coord_t exp, string what);
		if (got !== exp)
			stop_run(error_text($sformatf("%s got (%0d,%0d) expected (%0d,%0d)",
				what, got.row, got.col, exp.row, exp.col)));
	endtask

	task automatic check_pixel(conv_pkg::pixel_t got, conv_pkg::pixel_t exp, string what);
		if (got !== exp)
			stop_run(error_text($sformatf("%s got %0d expected %0d", what, got, exp)));
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp)
			stop_run(error_text($sformatf("%s got %b expected %b", what, got, exp)));
	endtask

	// outputs arrive row-major over the valid window positions
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (out_valid === 1'b1)
			begin
				if (out_cnt >= OUT_PER_FRAME)
					stop_run(error_text("more outputs than window positions"));
				exp_coord.row = conv_pkg::coord_t'(out_cnt / OUT_W);
				exp_coord.col = conv_pkg::coord_t'(out_cnt % OUT_W);
				check_coord(out_coord, exp_coord, "out_coord");
				for (int ch = 0; ch < OUT_CH; ch++)
					check_pixel(out_data[ch], exp_out[out_cnt][ch],
						$sformatf("out_data[%0d] at output %0d", ch, out_cnt));
				check_flag(conv_done, out_cnt == OUT_PER_FRAME - 1, "conv_done");
				out_cnt++;
			end
			else
			begin
				check_flag(conv_done, 1'b0, "conv_done without out_valid");
			end
		end
	end

	function automatic int rand_range(int lo, int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	// convolution rule with wide arithmetic, then 16-bit truncation
	function automatic conv_pkg::pixel_t conv_ref(int r, int c, int ch);
		longint acc;
		acc = longint'(bias_mem[ch]) <<< conv_pkg::FRAC_BITS;
		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3; j++)
				acc += longint'(pix_mem[(r+i)*IMG_WIDTH+c+j]) *
					longint'(weight_mem[(3*i+j)*OUT_CH+ch]);
		end
		acc = acc >>> conv_pkg::FRAC_BITS;
		return conv_pkg::pixel_t'(acc);
	endfunction

	task automatic fill_expected();
		for (int r = 0; r < OUT_W; r++)
		begin
			for (int c = 0; c < OUT_W; c++)
			begin
				for (int ch = 0; ch < OUT_CH; ch++)
					exp_out[r*OUT_W+c][ch] = conv_ref(r, c, ch);
			end
		end
	endtask

	task automatic fill_random_coefs(int w_lo, int w_hi, int b_lo, int b_hi);
		for (int k = 0; k < NUM_WEIGHTS; k++)
			weight_mem[k] = conv_pkg::coef_t'(rand_range(w_lo, w_hi));
		for (int ch = 0; ch < OUT_CH; ch++)
			bias_mem[ch] = conv_pkg::coef_t'(rand_range(b_lo, b_hi));
	endtask

	task automatic fill_random_pixels(int lo, int hi);
		for (int p = 0; p < IMG_WIDTH * IMG_WIDTH; p++)
			pix_mem[p] = conv_pkg::pixel_t'(rand_range(lo, hi));
	endtask

	task automatic load_coefs();
		int cycles;
		@(posedge clk);
		weight_store_done <= 1'b1;
		bias_store_done <= 1'b1;
		@(posedge clk);
		weight_store_done <= 1'b0;
		bias_store_done <= 1'b0;
		// old ready drops once the new load starts
		@(posedge clk);
		check_flag(layer1_conv_i.weights_ready, 1'b0, "weights_ready during load");
		check_flag(layer1_conv_i.bias_ready, 1'b0, "bias_ready during load");
		cycles = 0;
		while (layer1_conv_i.weights_ready !== 1'b1 || layer1_conv_i.bias_ready !== 1'b1)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > LOAD_CYCLES)
				stop_run("coefficient load did not finish in time");
		end
	endtask

	task automatic run_frame();
		int cycles;
		out_cnt = 0;
		@(posedge clk);
		pixel_store_done <= 1'b1;
		@(posedge clk);
		pixel_store_done <= 1'b0;
		cycles = 0;
		while (conv_done !== 1'b1)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > FRAME_CYCLES)
				stop_run("frame did not finish in time");
		end
		// let the collector take the last output
		@(posedge clk);
		if (out_cnt != OUT_PER_FRAME)
			stop_run(error_text($sformatf("frame gave %0d outputs, expected %0d",
				out_cnt, OUT_PER_FRAME)));
	endtask

	task automatic test_reset();
		@(posedge clk);
		check_flag(pix_rd.en, 1'b0, "pix_rd.en after reset");
		check_flag(weight_rd.en, 1'b0, "weight_rd.en after reset");
		check_flag(bias_rd.en, 1'b0, "bias_rd.en after reset");
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_flag(conv_done, 1'b0, "conv_done after reset");
		check_flag(layer1_conv_i.weights_ready, 1'b0, "weights_ready after reset");
		check_flag(layer1_conv_i.bias_ready, 1'b0, "bias_ready after reset");
		pixel_store_done <= 1'b1;
		@(posedge clk);
		pixel_store_done <= 1'b0;
		// no frame may start without coefficients
		repeat (2 * IMG_WIDTH)
		begin
			@(posedge clk);
			check_flag(pix_rd.en, 1'b0, "pix_rd.en without coefficients");
		end
	endtask

	task automatic test_identity();
		for (int k = 0; k < NUM_WEIGHTS; k++)
			weight_mem[k] = (k / OUT_CH == 4) ? conv_pkg::coef_t'(ONE) : '0;
		for (int ch = 0; ch < OUT_CH; ch++)
			bias_mem[ch] = '0;
		fill_random_pixels(-2000, 2000);
		for (int r = 0; r < OUT_W; r++)
		begin
			for (int c = 0; c < OUT_W; c++)
			begin
				for (int ch = 0; ch < OUT_CH; ch++)
					exp_out[r*OUT_W+c][ch] = pix_mem[(r+1)*IMG_WIDTH+c+1];
			end
		end
		load_coefs();
		run_frame();
	endtask

	task automatic test_random();
		fill_random_coefs(-512, 511, -1024, 1023);
		fill_random_pixels(-1024, 1023);
		fill_expected();
		load_coefs();
		run_frame();
	endtask

	// same image, new coefficients
	task automatic test_reload();
		fill_random_coefs(-300, 300, -4000, 4000);
		fill_expected();
		load_coefs();
		run_frame();
	endtask

	task automatic test_wraparound();
		fill_random_coefs(20000, 32767, -32768, 32767);
		fill_random_pixels(20000, 32767);
		fill_expected();
		load_coefs();
		run_frame();
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_run("watchdog expired before the tests finished");
	end

	initial
	begin
		seed = 79;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		pixel_store_done = 1'b0;
		weight_data = '0;
		bias_data = '0;
		pixel_data = '0;
		out_cnt = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_identity();
		test_random();
		test_reload();
		test_wraparound();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- layer1_conv.f
hw/conv_pkg.sv
hw/coef_loader.sv
hw/line_window.sv
hw/conv_mac.sv
hw/scan_ctrl.sv
hw/layer1_conv.sv
dv/layer1_conv_tb.sv

//--- Bender.yml
package:
  name: layer1_conv

sources:
  - hw/conv_pkg.sv
  - hw/coef_loader.sv
  - hw/line_window.sv
  - hw/conv_mac.sv
  - hw/scan_ctrl.sv
  - hw/layer1_conv.sv
  - target: simulation
    files:
      - dv/layer1_conv_tb.sv
